// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module idct_tb -f verilog.f -o idct_sim \
	&& ./obj_dir/idct_sim | tee sim.log \
	&& grep -qx "RESULT: PASS" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }

// File: verification/idct_clock_gen.sv
`timescale 1ns/100ps

module idct_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic Clock,
	output logic Resetn
);

initial begin
	Clock = 1'b0;
	forever #(PERIOD / 2) Clock = ~Clock;
end

initial begin
	Resetn = 1'b0;
	repeat (RESET_CYCLES) @(posedge Clock);
	Resetn <= 1'b1;
end

endmodule

// File: verification/idct_tb.sv
`timescale 1ns/100ps

module idct_tb;

localparam int BS = idct_pkg::BLOCK_SIZE;
localparam int ROW_PITCH = 320;
localparam int SRAM_WORDS = 1 << $bits(idct_pkg::sram_addr_t);
// Six blocks with their coefficient loads plus margin for the idle checks and the held start
localparam int BLOCK_CYCLES = 1500;
localparam int TIMEOUT_CYCLES = 6 * BLOCK_CYCLES + 3000;

logic Clock;
logic Resetn;
logic start;
idct_pkg::sram_addr_t in_base;
idct_pkg::sram_addr_t out_base;
idct_pkg::sram_data_t sram_read_data = '0;
idct_pkg::sram_data_t read_stage = '0;
idct_pkg::sram_req_t sram;
logic busy;
logic finish;

logic load_en;
idct_pkg::sram_addr_t load_addr;
idct_pkg::sram_data_t load_data;
idct_pkg::sram_data_t mem [SRAM_WORDS];
idct_pkg::sram_data_t exp_mem [SRAM_WORDS];
idct_pkg::sample_t coef [BS][BS];
idct_pkg::pixel_t expect_pix [BS][BS];
int write_count = 0;
int finish_count = 0;
int error_count = 0;
int tests_passed = 0;
int tests_failed = 0;

idct_clock_gen #(
	.PERIOD(100),
	.RESET_CYCLES(10)
) idct_clock_gen_i (
	.Clock(Clock),
	.Resetn(Resetn)
);

idct_top #(
	.ROW_PITCH(ROW_PITCH)
) idct_top_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.start(start),
	.in_base(in_base),
	.out_base(out_base),
	.sram_read_data(sram_read_data),
	.sram(sram),
	.busy(busy),
	.finish(finish)
);

function automatic idct_pkg::sram_data_t fill_value(input idct_pkg::sram_addr_t a);
	return a[15:0] ^ {a[1:0], a[17:4]} ^ 16'h6c1d;
endfunction

// SRAM with two cycles from address to data and a backdoor loader port
initial begin
	for (int a = 0; a < SRAM_WORDS; a++) begin
		mem[a] = fill_value(idct_pkg::sram_addr_t'(a));
	end
	forever begin
		@(posedge Clock);
		if (load_en) begin
			mem[load_addr] = load_data;
		end
		// Writes are ignored while the DUT is held in reset
		if (Resetn && !sram.sram_we_n) begin
			mem[sram.sram_address] = sram.sram_write_data;
			write_count++;
		end
		sram_read_data <= read_stage;
		read_stage <= mem[sram.sram_address];
	end
end

always @(posedge Clock) begin
	if (Resetn && finish) begin
		finish_count <= finish_count + 1;
	end
end

initial begin
	int cycles;
	cycles = 0;
	while (cycles < TIMEOUT_CYCLES) begin
		@(posedge Clock);
		cycles++;
	end
	$display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
	$display("RESULT: FAIL");
	$finish;
end

task automatic note_failure(input string msg);
	$display("[ERROR] %0t ns %s", $time, msg);
	error_count++;
endtask

task automatic check_pixel(input string name, input idct_pkg::pixel_t expected,
		input idct_pkg::pixel_t actual);
	if (actual !== expected) begin
		$display("[FAIL] %0t ns %s expected %02h actual %02h", $time, name, expected, actual);
		error_count++;
	end
endtask

task automatic check_word(input string name, input idct_pkg::sram_data_t expected,
		input idct_pkg::sram_data_t actual);
	if (actual !== expected) begin
		$display("[FAIL] %0t ns %s expected %04h actual %04h", $time, name, expected, actual);
		error_count++;
	end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("[FAIL] %0t ns %s expected %b actual %b", $time, name, expected, actual);
		error_count++;
	end
endtask

task automatic report_test(input string name, input int errs_before);
	if (error_count == errs_before) begin
		$display("Test %s: passed", name);
		tests_passed++;
	end else begin
		$display("Test %s: failed with %0d errors", name, error_count - errs_before);
		tests_failed++;
	end
endtask

// A zero range gives an all-zero block
task automatic random_block(input int range);
	for (int r = 0; r < BS; r++) begin
		for (int c = 0; c < BS; c++) begin
			coef[r][c] = idct_pkg::sample_t'(int'($urandom_range(2 * range, 0)) - range);
		end
	end
endtask

task automatic load_block(input idct_pkg::sram_addr_t base);
	idct_pkg::sram_addr_t addr;
	for (int r = 0; r < BS; r++) begin
		for (int c = 0; c < BS; c++) begin
			addr = base + idct_pkg::sram_addr_t'(r * ROW_PITCH + c);
			exp_mem[addr] = idct_pkg::sram_data_t'(coef[r][c]);
			@(posedge Clock);
			load_en <= 1'b1;
			load_addr <= addr;
			load_data <= idct_pkg::sram_data_t'(coef[r][c]);
		end
	end
	@(posedge Clock);
	load_en <= 1'b0;
endtask

// Row pass S x C then column pass C transposed x T clipped to a pixel
task automatic compute_model();
	int t [BS][BS];
	int acc;
	for (int r = 0; r < BS; r++) begin
		for (int c = 0; c < BS; c++) begin
			acc = 0;
			for (int k = 0; k < BS; k++) begin
				acc += int'(coef[r][k]) * int'(idct_pkg::COS_TABLE[k][c]);
			end
			t[r][c] = acc >>> idct_pkg::PASS1_SHIFT;
		end
	end
	for (int r = 0; r < BS; r++) begin
		for (int c = 0; c < BS; c++) begin
			acc = 0;
			for (int k = 0; k < BS; k++) begin
				acc += int'(idct_pkg::COS_TABLE[k][r]) * t[k][c];
			end
			acc = acc >>> idct_pkg::PASS2_SHIFT;
			if (acc < 0) begin
				expect_pix[r][c] = 8'h00;
			end else if (acc > 255) begin
				expect_pix[r][c] = 8'hff;
			end else begin
				expect_pix[r][c] = idct_pkg::pixel_t'(acc);
			end
		end
	end
endtask

task automatic store_expected(input idct_pkg::sram_addr_t base);
	idct_pkg::sram_addr_t addr;
	for (int r = 0; r < BS; r++) begin
		for (int j = 0; j < BS / 2; j++) begin
			addr = base + idct_pkg::sram_addr_t'(r * (ROW_PITCH / 2) + j);
			exp_mem[addr] = {expect_pix[r][2 * j], expect_pix[r][2 * j + 1]};
		end
	end
endtask

task automatic check_block(input idct_pkg::sram_addr_t base);
	idct_pkg::sram_addr_t addr;
	idct_pkg::sram_data_t word;
	for (int r = 0; r < BS; r++) begin
		for (int j = 0; j < BS / 2; j++) begin
			addr = base + idct_pkg::sram_addr_t'(r * (ROW_PITCH / 2) + j);
			word = mem[addr];
			check_pixel($sformatf("pixel[%0d][%0d]", r, 2 * j), expect_pix[r][2 * j],
				word[15:8]);
			check_pixel($sformatf("pixel[%0d][%0d]", r, 2 * j + 1), expect_pix[r][2 * j + 1],
				word[7:0]);
		end
	end
endtask

task automatic wait_finish();
	do begin
		@(posedge Clock);
	end while (finish !== 1'b1);
endtask

task automatic pulse_start(input idct_pkg::sram_addr_t in_addr,
		input idct_pkg::sram_addr_t out_addr);
	@(posedge Clock);
	in_base <= in_addr;
	out_base <= out_addr;
	start <= 1'b1;
	@(posedge Clock);
	start <= 1'b0;
endtask

task automatic prepare_block(input idct_pkg::sram_addr_t in_addr,
		input idct_pkg::sram_addr_t out_addr);
	load_block(in_addr);
	compute_model();
	store_expected(out_addr);
endtask

task automatic run_block(input idct_pkg::sram_addr_t in_addr,
		input idct_pkg::sram_addr_t out_addr);
	prepare_block(in_addr, out_addr);
	pulse_start(in_addr, out_addr);
	@(posedge Clock);
	check_flag("busy", 1'b1, busy);
	wait_finish();
	check_flag("busy", 1'b0, busy);
	@(posedge Clock);
	check_flag("finish", 1'b0, finish);
	check_block(out_addr);
endtask

task automatic compare_memory();
	int mismatches;
	mismatches = 0;
	for (int a = 0; a < SRAM_WORDS; a++) begin
		if (mem[a] !== exp_mem[a] && mismatches < 16) begin
			check_word($sformatf("sram[%05h]", a), exp_mem[a], mem[a]);
			mismatches++;
		end
	end
endtask

initial begin
	int errs;
	int fin_before;
	int n_high;
	int n_low;
	idct_pkg::sram_addr_t addr;
	start = 1'b0;
	in_base = '0;
	out_base = '0;
	load_en = 1'b0;
	load_addr = '0;
	load_data = '0;
	void'($urandom(32'h2b36));
	for (int a = 0; a < SRAM_WORDS; a++) begin
		exp_mem[a] = fill_value(idct_pkg::sram_addr_t'(a));
	end
	wait (Resetn === 1'b1);

	errs = error_count;
	repeat (10) @(posedge Clock);
	check_flag("busy", 1'b0, busy);
	check_flag("finish", 1'b0, finish);
	check_flag("sram_we_n", 1'b1, sram.sram_we_n);
	if (write_count != 0) begin
		note_failure("the SRAM was written before any start");
	end
	report_test("1 idle after reset", errs);

	errs = error_count;
	random_block(0);
	run_block(18'h00100, 18'h08000);
	for (int r = 0; r < BS; r++) begin
		for (int j = 0; j < BS / 2; j++) begin
			addr = 18'h08000 + idct_pkg::sram_addr_t'(r * (ROW_PITCH / 2) + j);
			check_word($sformatf("sram[%05h]", addr), 16'h0000, mem[addr]);
		end
	end
	report_test("2 zero block", errs);

	errs = error_count;
	random_block(256);
	run_block(18'h02000, 18'h09000);
	report_test("3 random small block", errs);

	// Strong first horizontal frequency drives the left half high and the right half low
	errs = error_count;
	random_block(64);
	coef[0][1] = 16'sd4000;
	run_block(18'h04000, 18'h0a000);
	n_high = 0;
	n_low = 0;
	for (int r = 0; r < BS; r++) begin
		for (int c = 0; c < BS; c++) begin
			if (expect_pix[r][c] == 8'hff) begin
				n_high++;
			end
			if (expect_pix[r][c] == 8'h00) begin
				n_low++;
			end
		end
	end
	if (n_high == 0 || n_low == 0) begin
		note_failure("the saturation block did not reach both pixel limits");
	end
	report_test("4 saturated block", errs);

	errs = error_count;
	random_block(256);
	run_block(18'h10000, 18'h3c000);
	random_block(1024);
	run_block(18'h20123, 18'h30055);
	compare_memory();
	report_test("5 two blocks and untouched memory", errs);

	// Start stays high apart from one extra rising edge while busy
	errs = error_count;
	fin_before = finish_count;
	random_block(256);
	prepare_block(18'h06000, 18'h0b000);
	@(posedge Clock);
	in_base <= 18'h06000;
	out_base <= 18'h0b000;
	start <= 1'b1;
	repeat (200) @(posedge Clock);
	check_flag("busy", 1'b1, busy);
	start <= 1'b0;
	@(posedge Clock);
	start <= 1'b1;
	wait_finish();
	// Long enough for a wrongly accepted block to finish too
	repeat (BLOCK_CYCLES) @(posedge Clock);
	if (finish_count - fin_before != 1) begin
		note_failure($sformatf("one accepted start gave %0d finish pulses",
			finish_count - fin_before));
	end
	start <= 1'b0;
	repeat (5) @(posedge Clock);
	check_flag("busy", 1'b0, busy);
	check_block(18'h0b000);
	report_test("6 start held and pulsed while busy", errs);

	$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
		tests_passed, tests_failed, error_count);
	if (error_count == 0) begin
		$display("RESULT: PASS");
	end else begin
		$display("RESULT: FAIL");
	end
	$finish;
end

endmodule

// File: verilog.f
verilog/idct_pkg.sv
verilog/block_ram.sv
verilog/mac_unit.sv
verilog/sram_block_io.sv
verilog/matrix_sequencer.sv
verilog/idct_top.sv
verification/idct_clock_gen.sv
verification/idct_tb.sv

// File: verilog/block_ram.sv
`timescale 1ns/100ps

module block_ram #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 64
) (
	input logic Clock,
	input idct_pkg::ram_wr_t wr,
	input idct_pkg::buf_addr_t rd_addr,
	output logic [WIDTH-1:0] rd_data
);

localparam int AW = $clog2(DEPTH);

logic [WIDTH-1:0] mem [DEPTH];

// Read returns the old contents on a same-address write
always_ff @(posedge Clock) begin
	if (wr.en) begin
		mem[wr.addr[AW-1:0]] <= wr.data[WIDTH-1:0];
	end
	rd_data <= mem[rd_addr[AW-1:0]];
end

endmodule

// File: verilog/idct_pkg.sv
package idct_pkg;

	localparam int BLOCK_SIZE = 8;
	localparam int SRAM_LATENCY = 2;
	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic signed [15:0] sample_t;
	typedef logic signed [15:0] coeff_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;
	typedef logic [5:0] buf_addr_t;

	typedef struct packed {
		buf_addr_t addr;
		acc_t data;
		logic en;
	} ram_wr_t;

	typedef struct packed {
		sram_addr_t sram_address;
		sram_data_t sram_write_data;
		logic sram_we_n;
	} sram_req_t;

	typedef enum logic [1:0] {IO_IDLE, IO_FETCH, IO_DRAIN, IO_WRITE} io_state_t;
	typedef enum logic [1:0] {SEQ_IDLE, SEQ_ROW, SEQ_COLUMN} seq_state_t;
	typedef enum logic {PASS_ROW, PASS_COLUMN} pass_t;

	// Scaled cosine basis, first index is frequency k, second is sample n
	localparam coeff_t COS_TABLE [0:BLOCK_SIZE-1][0:BLOCK_SIZE-1] = '{
		'{16'sd2048, 16'sd2048, 16'sd2048, 16'sd2048,
			16'sd2048, 16'sd2048, 16'sd2048, 16'sd2048},
		'{16'sd2841, 16'sd2408, 16'sd1609, 16'sd565,
			-16'sd565, -16'sd1609, -16'sd2408, -16'sd2841},
		'{16'sd2676, 16'sd1108, -16'sd1108, -16'sd2676,
			-16'sd2676, -16'sd1108, 16'sd1108, 16'sd2676},
		'{16'sd2408, -16'sd565, -16'sd2841, -16'sd1609,
			16'sd1609, 16'sd2841, 16'sd565, -16'sd2408},
		'{16'sd2048, -16'sd2048, -16'sd2048, 16'sd2048,
			16'sd2048, -16'sd2048, -16'sd2048, 16'sd2048},
		'{16'sd1609, -16'sd2841, 16'sd565, 16'sd2408,
			-16'sd2408, -16'sd565, 16'sd2841, -16'sd1609},
		'{16'sd1108, -16'sd2676, 16'sd2676, -16'sd1108,
			-16'sd1108, 16'sd2676, -16'sd2676, 16'sd1108},
		'{16'sd565, -16'sd1609, 16'sd2408, -16'sd2841,
			16'sd2841, -16'sd2408, 16'sd1609, -16'sd565}
	};

endpackage

// File: verilog/idct_top.sv
`timescale 1ns/100ps

module idct_top #(
	parameter int ROW_PITCH = 320
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input idct_pkg::sram_addr_t in_base,
	input idct_pkg::sram_addr_t out_base,
	input idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_req_t sram,
	output logic busy,
	output logic finish
);

idct_pkg::ram_wr_t sample_wr;
idct_pkg::ram_wr_t inter_wr;
idct_pkg::ram_wr_t pixel_wr;
idct_pkg::buf_addr_t sample_rd_addr;
idct_pkg::buf_addr_t inter_rd_addr;
idct_pkg::buf_addr_t pixel_rd_addr;
idct_pkg::sram_data_t sample_rd_data;
idct_pkg::sram_data_t pixel_rd_data;
idct_pkg::acc_t inter_rd_data;
idct_pkg::acc_t op_a;
idct_pkg::acc_t mac_result;
idct_pkg::coeff_t op_b;
idct_pkg::pass_t pass;
logic mac_clear;
logic mac_enable;
logic fetch_done;
logic write_start;

sram_block_io #(
	.ROW_PITCH(ROW_PITCH)
) sram_block_io_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.start(start),
	.in_base(in_base),
	.out_base(out_base),
	.sram_read_data(sram_read_data),
	.sram(sram),
	.sample_wr(sample_wr),
	.pixel_rd_addr(pixel_rd_addr),
	.pixel_rd_data(pixel_rd_data),
	.write_start(write_start),
	.fetch_done(fetch_done),
	.busy(busy),
	.finish(finish)
);

matrix_sequencer matrix_sequencer_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.fetch_done(fetch_done),
	.sample_rd_addr(sample_rd_addr),
	.inter_rd_addr(inter_rd_addr),
	.sample_rd_data(sample_rd_data),
	.inter_rd_data(inter_rd_data),
	.inter_wr(inter_wr),
	.pixel_wr(pixel_wr),
	.op_a(op_a),
	.op_b(op_b),
	.mac_clear(mac_clear),
	.mac_enable(mac_enable),
	.pass(pass),
	.mac_result(mac_result),
	.write_start(write_start)
);

mac_unit mac_unit_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.op_a(op_a),
	.op_b(op_b),
	.mac_clear(mac_clear),
	.mac_enable(mac_enable),
	.pass(pass),
	.mac_result(mac_result)
);

// Coefficients as read from SRAM
block_ram #(
	.WIDTH(16),
	.DEPTH(64)
) sample_buf (
	.Clock(Clock),
	.wr(sample_wr),
	.rd_addr(sample_rd_addr),
	.rd_data(sample_rd_data)
);

block_ram #(
	.WIDTH(32),
	.DEPTH(64)
) inter_buf (
	.Clock(Clock),
	.wr(inter_wr),
	.rd_addr(inter_rd_addr),
	.rd_data(inter_rd_data)
);

// Pixel pairs, one SRAM word each
block_ram #(
	.WIDTH(16),
	.DEPTH(32)
) pixel_buf (
	.Clock(Clock),
	.wr(pixel_wr),
	.rd_addr(pixel_rd_addr),
	.rd_data(pixel_rd_data)
);

endmodule

// File: verilog/mac_unit.sv
`timescale 1ns/100ps

module mac_unit (
	input logic Clock,
	input logic Resetn,
	input idct_pkg::acc_t op_a,
	input idct_pkg::coeff_t op_b,
	input logic mac_clear,
	input logic mac_enable,
	input idct_pkg::pass_t pass,
	output idct_pkg::acc_t mac_result
);

idct_pkg::acc_t accumulator;
idct_pkg::acc_t product;
idct_pkg::acc_t column_sum;
idct_pkg::pixel_t pixel;

// Product keeps only the low 32 bits
assign product = op_a * idct_pkg::acc_t'(op_b);

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		accumulator <= '0;
	end else if (mac_enable) begin
		// Clear arrives together with the first operand of a sum
		accumulator <= (mac_clear ? idct_pkg::acc_t'(0) : accumulator) + product;
	end
end

always_comb begin
	column_sum = accumulator >>> idct_pkg::PASS2_SHIFT;
	if (column_sum < 0) begin
		pixel = 8'h00;
	end else if (column_sum > 255) begin
		pixel = 8'hff;
	end else begin
		pixel = column_sum[7:0];
	end
	if (pass == idct_pkg::PASS_COLUMN) begin
		mac_result = {24'd0, pixel};
	end else begin
		mac_result = accumulator >>> idct_pkg::PASS1_SHIFT;
	end
end

endmodule

// File: verilog/matrix_sequencer.sv
`timescale 1ns/100ps

module matrix_sequencer (
	input logic Clock,
	input logic Resetn,
	input logic fetch_done,
	output idct_pkg::buf_addr_t sample_rd_addr,
	output idct_pkg::buf_addr_t inter_rd_addr,
	input idct_pkg::sram_data_t sample_rd_data,
	input idct_pkg::acc_t inter_rd_data,
	output idct_pkg::ram_wr_t inter_wr,
	output idct_pkg::ram_wr_t pixel_wr,
	output idct_pkg::acc_t op_a,
	output idct_pkg::coeff_t op_b,
	output logic mac_clear,
	output logic mac_enable,
	output idct_pkg::pass_t pass,
	input idct_pkg::acc_t mac_result,
	output logic write_start
);

// Eight operand cycles and two drain cycles per output element
localparam int LAST_PHASE = idct_pkg::BLOCK_SIZE + 1;

idct_pkg::seq_state_t state;
logic [3:0] phase;
logic [2:0] row;
logic [2:0] col;
logic [2:0] k;
logic issue;
logic result_valid;
logic last_pixel;
idct_pkg::pixel_t pixel_hold;

assign k = phase[2:0];
assign issue = (state != idct_pkg::SEQ_IDLE) && (phase < 4'(idct_pkg::BLOCK_SIZE));
assign result_valid = (state != idct_pkg::SEQ_IDLE) && (phase == 4'(LAST_PHASE));
assign pass = (state == idct_pkg::SEQ_COLUMN) ? idct_pkg::PASS_COLUMN : idct_pkg::PASS_ROW;

// Row pass walks S[r][k], column pass walks T[k][c]
assign sample_rd_addr = {row, k};
assign inter_rd_addr = {k, col};

always_comb begin
	if (pass == idct_pkg::PASS_COLUMN) begin
		op_a = inter_rd_data;
	end else begin
		op_a = idct_pkg::acc_t'(idct_pkg::sample_t'(sample_rd_data));
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= idct_pkg::SEQ_IDLE;
		phase <= '0;
		row <= '0;
		col <= '0;
	end else if (state == idct_pkg::SEQ_IDLE) begin
		phase <= '0;
		row <= '0;
		col <= '0;
		if (fetch_done) begin
			state <= idct_pkg::SEQ_ROW;
		end
	end else if (result_valid) begin
		phase <= '0;
		col <= col + 3'd1;
		if (col == 3'd7) begin
			row <= row + 3'd1;
			if (row == 3'd7 && state == idct_pkg::SEQ_ROW) begin
				state <= idct_pkg::SEQ_COLUMN;
			end else if (row == 3'd7) begin
				state <= idct_pkg::SEQ_IDLE;
			end
		end
	end else begin
		phase <= phase + 4'd1;
	end
end

// Table entry lines up with the buffer read data
always_ff @(posedge Clock) begin
	if (state == idct_pkg::SEQ_COLUMN) begin
		op_b <= idct_pkg::COS_TABLE[k][row];
	end else begin
		op_b <= idct_pkg::COS_TABLE[k][col];
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		mac_enable <= 1'b0;
		mac_clear <= 1'b0;
		inter_wr <= '0;
		pixel_wr <= '0;
		pixel_hold <= '0;
		last_pixel <= 1'b0;
		write_start <= 1'b0;
	end else begin
		mac_enable <= issue;
		mac_clear <= issue && (phase == 4'd0);
		inter_wr.en <= result_valid && (state == idct_pkg::SEQ_ROW);
		pixel_wr.en <= result_valid && (state == idct_pkg::SEQ_COLUMN) && col[0];
		last_pixel <= result_valid && (state == idct_pkg::SEQ_COLUMN) &&
			(row == 3'd7) && (col == 3'd7);
		write_start <= last_pixel;
		if (result_valid) begin
			inter_wr.addr <= {row, col};
			inter_wr.data <= mac_result;
			// Even column waits for its odd neighbour
			pixel_wr.addr <= {1'b0, row, col[2:1]};
			pixel_wr.data <= {16'd0, pixel_hold, mac_result[7:0]};
			if (!col[0]) begin
				pixel_hold <= mac_result[7:0];
			end
		end
	end
end

endmodule

// File: verilog/sram_block_io.sv
`timescale 1ns/100ps

module sram_block_io #(
	parameter int ROW_PITCH = 320
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input idct_pkg::sram_addr_t in_base,
	input idct_pkg::sram_addr_t out_base,
	input idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_req_t sram,
	output idct_pkg::ram_wr_t sample_wr,
	output idct_pkg::buf_addr_t pixel_rd_addr,
	input idct_pkg::sram_data_t pixel_rd_data,
	input logic write_start,
	output logic fetch_done,
	output logic busy,
	output logic finish
);

localparam idct_pkg::sram_addr_t COEFF_ROW_STEP = idct_pkg::sram_addr_t'(ROW_PITCH);
localparam idct_pkg::sram_addr_t PIXEL_ROW_STEP = idct_pkg::sram_addr_t'(ROW_PITCH / 2);
// Lead-in read, 32 pair writes, then one cycle for the last write
localparam idct_pkg::buf_addr_t LAST_WRITE_COUNT =
	idct_pkg::buf_addr_t'(idct_pkg::BLOCK_SIZE * idct_pkg::BLOCK_SIZE / 2 + 1);

idct_pkg::io_state_t state;
idct_pkg::buf_addr_t count;
idct_pkg::buf_addr_t pair_idx;
idct_pkg::sram_addr_t row_base;
idct_pkg::sram_addr_t out_base_r;
logic start_d;
logic start_edge;
logic [idct_pkg::SRAM_LATENCY:0] fetch_valid;
idct_pkg::buf_addr_t fetch_idx [idct_pkg::SRAM_LATENCY+1];

assign start_edge = start && !start_d;
assign pair_idx = count - 6'd1;
assign pixel_rd_addr = count;

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= idct_pkg::IO_IDLE;
		count <= '0;
		row_base <= '0;
		out_base_r <= '0;
		start_d <= 1'b0;
		busy <= 1'b0;
		finish <= 1'b0;
		sram <= '{sram_address: '0, sram_write_data: '0, sram_we_n: 1'b1};
	end else begin
		start_d <= start;
		finish <= 1'b0;
		sram.sram_we_n <= 1'b1;
		case (state)
			idct_pkg::IO_IDLE: begin
				if (start_edge) begin
					busy <= 1'b1;
					row_base <= in_base;
					out_base_r <= out_base;
					count <= '0;
					state <= idct_pkg::IO_FETCH;
				end
			end
			idct_pkg::IO_FETCH: begin
				sram.sram_address <= row_base + idct_pkg::sram_addr_t'(count[2:0]);
				count <= count + 6'd1;
				if (count[2:0] == 3'd7) begin
					row_base <= row_base + COEFF_ROW_STEP;
				end
				if (&count) begin
					state <= idct_pkg::IO_DRAIN;
				end
			end
			idct_pkg::IO_DRAIN: begin
				// Holds here while the matrix passes run
				if (write_start) begin
					row_base <= out_base_r;
					count <= '0;
					state <= idct_pkg::IO_WRITE;
				end
			end
			idct_pkg::IO_WRITE: begin
				count <= count + 6'd1;
				if (count == LAST_WRITE_COUNT) begin
					finish <= 1'b1;
					busy <= 1'b0;
					state <= idct_pkg::IO_IDLE;
				end else if (count != '0) begin
					sram.sram_address <= row_base + idct_pkg::sram_addr_t'(pair_idx[1:0]);
					sram.sram_write_data <= pixel_rd_data;
					sram.sram_we_n <= 1'b0;
					if (pair_idx[1:0] == 2'd3) begin
						row_base <= row_base + PIXEL_ROW_STEP;
					end
				end
			end
		endcase
	end
end

// Sample index follows its address through the SRAM latency
always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		fetch_valid <= '0;
		sample_wr <= '0;
		fetch_done <= 1'b0;
	end else begin
		fetch_valid <= {fetch_valid[idct_pkg::SRAM_LATENCY-1:0], state == idct_pkg::IO_FETCH};
		sample_wr.en <= fetch_valid[idct_pkg::SRAM_LATENCY];
		sample_wr.addr <= fetch_idx[idct_pkg::SRAM_LATENCY];
		sample_wr.data <= idct_pkg::acc_t'(idct_pkg::sample_t'(sram_read_data));
		fetch_done <= sample_wr.en && (&sample_wr.addr);
	end
end

always_ff @(posedge Clock) begin
	fetch_idx[0] <= count;
	for (int i = 1; i <= idct_pkg::SRAM_LATENCY; i++) begin
		fetch_idx[i] <= fetch_idx[i-1];
	end
end

endmodule
